/* bt_pkg.sv */
`default_nettype none

package bt_pkg;

  //////////////////////////////////////////////////
  // slot timing
  //////////////////////////////////////////////////

  // clk_6M cycles per microsecond tick
  localparam int unsigned TICKS_PER_US    = 6;
  // 312.5 us half slot counted straight in clk_6M cycles
  localparam int unsigned HALF_SLOT_TICKS = 1875;
  // counter widths for the two dividers
  localparam int unsigned US_CNT_W        = $clog2(TICKS_PER_US);
  localparam int unsigned HALF_CNT_W      = $clog2(HALF_SLOT_TICKS);
  // native clock, one count per half slot
  localparam int unsigned CLKN_W          = 28;

  //////////////////////////////////////////////////
  // sync word correlation and scan
  //////////////////////////////////////////////////

  localparam int unsigned SYNC_W     = 64;
  // agreement count, 0..64
  localparam int unsigned CORR_W     = 7;
  // scan interval / window, in slots
  localparam int unsigned SLOT_CNT_W = 16;

  typedef enum logic [1:0] {
    ST_STANDBY   = 2'd0,
    ST_PAGE_SCAN = 2'd1,
    ST_INQ_SCAN  = 2'd2,
    ST_CONN      = 2'd3
  } link_state_t;

  // shared timebase, 31 bits
  typedef struct packed {
    logic              p_1us;
    logic              half_tslot_p;
    logic              tslot_p;
    logic [CLKN_W-1:0] clkn;
  } timebase_t;

  // access codes the receiver can look for
  typedef struct packed {
    logic [SYNC_W-1:0] cac;
    logic [SYNC_W-1:0] dac;
    logic [SYNC_W-1:0] giac;
  } sync_words_t;

  // scan timing, all in slots
  typedef struct packed {
    logic [SLOT_CNT_W-1:0] ps_interval;
    logic [SLOT_CNT_W-1:0] ps_window;
    logic [SLOT_CNT_W-1:0] is_interval;
    logic [SLOT_CNT_W-1:0] is_window;
  } scan_cfg_t;

  // one-cycle hit pulses per link state
  typedef struct packed {
    logic ps_sync_p;
    logic is_sync_p;
    logic conn_sync_p;
  } sync_events_t;

endpackage

`default_nettype wire

/* bt_native_clk.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_native_clk (
  input  wire                  clk_6M,
  input  wire                  rstz,
  output bt_pkg::timebase_t    tb
);

  import bt_pkg::*;

  //////////////////////////////////////////////////
  // microsecond divider
  //////////////////////////////////////////////////

  // counts 0..5, wraps on the tick
  logic [US_CNT_W-1:0]   us_cnt;
  logic                  p_1us;

  // tick seen by the 6th edge after reset release
  assign p_1us = (us_cnt == US_CNT_W'(TICKS_PER_US - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      us_cnt <= '0;
    else if (p_1us)
      us_cnt <= '0;
    else
      us_cnt <= us_cnt + US_CNT_W'(1);
  end

  //////////////////////////////////////////////////
  // half slot / slot
  //////////////////////////////////////////////////

  // counts 0..1874 in clk_6M cycles
  logic [HALF_CNT_W-1:0] half_cnt;
  logic                  half_tslot_p;
  // set after the first half of a slot
  logic                  slot_half;
  logic                  tslot_p;

  assign half_tslot_p = (half_cnt == HALF_CNT_W'(HALF_SLOT_TICKS - 1));
  // every second half slot closes a full slot
  assign tslot_p      = half_tslot_p & slot_half;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      half_cnt  <= '0;
      slot_half <= 1'b0;
    end
    else if (half_tslot_p)
    begin
      half_cnt  <= '0;
      slot_half <= ~slot_half;
    end
    else
      half_cnt <= half_cnt + HALF_CNT_W'(1);
  end

  //////////////////////////////////////////////////
  // native clock
  //////////////////////////////////////////////////

  logic [CLKN_W-1:0] clkn;

  // one count per half slot, wraps at 2^28
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      clkn <= '0;
    else if (half_tslot_p)
      clkn <= clkn + CLKN_W'(1);
  end

  // pack the timebase
  always_comb
  begin
    tb.p_1us        = p_1us;
    tb.half_tslot_p = half_tslot_p;
    tb.tslot_p      = tslot_p;
    tb.clkn         = clkn;
  end

endmodule

`default_nettype wire

/* rx_sync_correlator.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_sync_correlator (
  input  wire                        clk_6M,
  input  wire                        rstz,
  input  wire                        rxbit,
  input  wire                        p_1us,
  input  wire                        corr_en,
  input  wire [bt_pkg::SYNC_W-1:0]   expected_sync,
  input  wire [bt_pkg::CORR_W-1:0]   corr_threshold,
  output logic                       sync_hit_p
);

  import bt_pkg::*;

  //////////////////////////////////////////////////
  // resync of the air bit
  //////////////////////////////////////////////////

  // two flops, rxbit is asynchronous to clk_6M
  logic [1:0] rx_meta;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_meta <= 2'b00;
    else
      rx_meta <= {rx_meta[0], rxbit};
  end

  //////////////////////////////////////////////////
  // 64-bit sliding window
  //////////////////////////////////////////////////

  // bit 63 oldest, word arrives msb first
  logic [SYNC_W-1:0] window;
  // marks the cycle after a sampling edge
  logic              samp_d;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      window <= '0;
      samp_d <= 1'b0;
    end
    else
    begin
      samp_d <= p_1us;
      // one sample per microsecond
      if (p_1us)
        window <= {window[SYNC_W-2:0], rx_meta[1]};
    end
  end

  //////////////////////////////////////////////////
  // agreement count
  //////////////////////////////////////////////////

  // 1 where the window bit equals the expected bit
  logic [SYNC_W-1:0] match;
  logic [CORR_W-1:0] ones;
  logic [CORR_W-1:0] agree_cnt;
  logic              cnt_vld;

  assign match = ~(window ^ expected_sync);

  // popcount of the match vector
  always_comb
  begin
    ones = '0;
    for (int i = 0; i < SYNC_W; i++)
      ones = ones + CORR_W'(match[i]);
  end

  // count registered once per new sample
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      agree_cnt <= '0;
      cnt_vld   <= 1'b0;
    end
    else
    begin
      cnt_vld <= samp_d;
      if (samp_d)
        agree_cnt <= ones;
    end
  end

  //////////////////////////////////////////////////
  // threshold compare
  //////////////////////////////////////////////////

  // hit two edges after the sampling edge
  // only while the scan window or link is open
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sync_hit_p <= 1'b0;
    else
      sync_hit_p <= cnt_vld & corr_en & (agree_cnt >= corr_threshold);
  end

endmodule

`default_nettype wire

/* scan_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl (
  input  wire                          clk_6M,
  input  wire                          rstz,
  input  bt_pkg::timebase_t            tb,
  input  bt_pkg::sync_words_t          words,
  input  bt_pkg::scan_cfg_t            scan_cfg,
  input  wire                          page_scan_enable_p,
  input  wire                          page_scan_cancel_p,
  input  wire                          inquiry_scan_enable,
  input  wire                          conn_hold_p,
  input  wire                          sync_hit_p,
  output bt_pkg::link_state_t          link_state,
  output bt_pkg::sync_events_t         events,
  output logic                         corr_en,
  output logic [bt_pkg::SYNC_W-1:0]    expected_sync
);

  import bt_pkg::*;

  //////////////////////////////////////////////////
  // link state FSM
  //////////////////////////////////////////////////

  link_state_t state;
  link_state_t state_nxt;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_STANDBY:
      begin
        // page scan request wins over inquiry scan level
        if (page_scan_enable_p)
          state_nxt = ST_PAGE_SCAN;
        else if (inquiry_scan_enable)
          state_nxt = ST_INQ_SCAN;
      end
      ST_PAGE_SCAN:
      begin
        // DAC found, slave side of the page response
        if (sync_hit_p)
          state_nxt = ST_CONN;
        else if (page_scan_cancel_p)
          state_nxt = ST_STANDBY;
      end
      ST_INQ_SCAN:
      begin
        // stays while the host keeps the level up
        if (!inquiry_scan_enable)
          state_nxt = ST_STANDBY;
      end
      ST_CONN:
      begin
        if (conn_hold_p)
          state_nxt = ST_STANDBY;
      end
      default:
        state_nxt = ST_STANDBY;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= ST_STANDBY;
    else
      state <= state_nxt;
  end

  assign link_state = state;

  //////////////////////////////////////////////////
  // scan interval / window
  //////////////////////////////////////////////////

  logic                  in_scan;
  logic [SLOT_CNT_W-1:0] cur_interval;
  logic [SLOT_CNT_W-1:0] cur_window;
  // slot index within the current interval
  logic [SLOT_CNT_W-1:0] slot_cnt;
  logic [SLOT_CNT_W-1:0] slot_inc;

  assign in_scan = (state == ST_PAGE_SCAN) || (state == ST_INQ_SCAN);

  // interval and window of the active scan
  always_comb
  begin
    if (state == ST_INQ_SCAN)
    begin
      cur_interval = scan_cfg.is_interval;
      cur_window   = scan_cfg.is_window;
    end
    else
    begin
      cur_interval = scan_cfg.ps_interval;
      cur_window   = scan_cfg.ps_window;
    end
  end

  assign slot_inc = slot_cnt + SLOT_CNT_W'(1);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_cnt <= '0;
    // restart on any state change, incl. scan entry
    else if (state_nxt != state)
      slot_cnt <= '0;
    else if (in_scan && tb.tslot_p)
    begin
      // wrap at the end of the interval
      if (slot_inc >= cur_interval)
        slot_cnt <= '0;
      else
        slot_cnt <= slot_inc;
    end
  end

  // listen at the start of each interval; always in a link
  always_comb
  begin
    if (state == ST_CONN)
      corr_en = 1'b1;
    else if (in_scan)
      corr_en = (slot_cnt < cur_window);
    else
      corr_en = 1'b0;
  end

  //////////////////////////////////////////////////
  // sync word select and hit routing
  //////////////////////////////////////////////////

  always_comb
  begin
    case (state)
      ST_PAGE_SCAN: expected_sync = words.dac;
      ST_INQ_SCAN:  expected_sync = words.giac;
      default:      expected_sync = words.cac;
    endcase
  end

  // same cycle as the correlator hit
  always_comb
  begin
    events.ps_sync_p   = sync_hit_p && (state == ST_PAGE_SCAN);
    events.is_sync_p   = sync_hit_p && (state == ST_INQ_SCAN);
    events.conn_sync_p = sync_hit_p && (state == ST_CONN);
  end

endmodule

`default_nettype wire

/* bt_rx_sync_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_rx_sync_top (
  input  wire                          clk_6M,
  input  wire                          rstz,
  input  bt_pkg::sync_words_t          words,
  input  bt_pkg::scan_cfg_t            scan_cfg,
  input  wire [bt_pkg::CORR_W-1:0]     corr_threshold,
  input  wire                          page_scan_enable_p,
  input  wire                          page_scan_cancel_p,
  input  wire                          inquiry_scan_enable,
  input  wire                          conn_hold_p,
  input  wire                          rxbit,
  output bt_pkg::link_state_t          link_state,
  output bt_pkg::sync_events_t         events,
  output logic [bt_pkg::CLKN_W-1:0]    clkn
);

  import bt_pkg::*;

  //////////////////////////////////////////////////
  // internal nets
  //////////////////////////////////////////////////

  timebase_t         tb;
  logic              corr_en;
  logic [SYNC_W-1:0] expected_sync;
  logic              sync_hit_p;

  // native clock out of the timebase
  assign clkn = tb.clkn;

  bt_native_clk u_native_clk (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .tb     (tb)
  );

  // receive side, sampled on the us tick
  rx_sync_correlator u_correlator (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .rxbit          (rxbit),
    .p_1us          (tb.p_1us),
    .corr_en        (corr_en),
    .expected_sync  (expected_sync),
    .corr_threshold (corr_threshold),
    .sync_hit_p     (sync_hit_p)
  );

  // link controller, picks word and window
  scan_ctrl u_scan_ctrl (
    .clk_6M              (clk_6M),
    .rstz                (rstz),
    .tb                  (tb),
    .words               (words),
    .scan_cfg            (scan_cfg),
    .page_scan_enable_p  (page_scan_enable_p),
    .page_scan_cancel_p  (page_scan_cancel_p),
    .inquiry_scan_enable (inquiry_scan_enable),
    .conn_hold_p         (conn_hold_p),
    .sync_hit_p          (sync_hit_p),
    .link_state          (link_state),
    .events              (events),
    .corr_en             (corr_en),
    .expected_sync       (expected_sync)
  );

endmodule

`default_nettype wire

/* bt_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_rx_checker (
  input  wire                   clk_6M,
  input  wire                   rstz,
  input  bt_pkg::link_state_t   link_state,
  input  bt_pkg::sync_events_t  events
);

  import bt_pkg::*;

  // ps, is, conn
  logic [2:0] ev;

  assign ev = {events.ps_sync_p, events.is_sync_p, events.conn_sync_p};

  //////////////////////////////////////////////////
  // event pulses
  //////////////////////////////////////////////////

  a_events_onehot: assert property (@(posedge clk_6M) disable iff (!rstz) $onehot0(ev))
    else $error("more than one sync event in one cycle");

  // single-cycle strobes
  a_ps_one_cycle: assert property (@(posedge clk_6M) disable iff (!rstz) ev[2] |=> !ev[2])
    else $error("ps_sync_p held longer than one cycle");
  a_is_one_cycle: assert property (@(posedge clk_6M) disable iff (!rstz) ev[1] |=> !ev[1])
    else $error("is_sync_p held longer than one cycle");
  a_conn_one_cycle: assert property (@(posedge clk_6M) disable iff (!rstz) ev[0] |=> !ev[0])
    else $error("conn_sync_p held longer than one cycle");

  //////////////////////////////////////////////////
  // link state
  //////////////////////////////////////////////////

  a_conn_in_link: assert property (@(posedge clk_6M) disable iff (!rstz)
                                   ev[0] |-> link_state == ST_CONN)
    else $error("conn_sync_p outside ST_CONN");

  // first edge after release
  a_reset_state: assert property (@(posedge clk_6M) $rose(rstz) |-> link_state == ST_STANDBY)
    else $error("link_state not ST_STANDBY after reset release");

endmodule

bind bt_rx_sync_top bt_rx_checker u_checker (
  .clk_6M     (clk_6M),
  .rstz       (rstz),
  .link_state (link_state),
  .events     (events)
);

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_6M,
  output logic rstz
);

  // 4 ns period
  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk_6M = 1'b0;
    forever
      #HALF_PERIOD clk_6M = ~clk_6M;
  end

  // release 1 ns after the 8th rising edge, clear of the clock edge
  initial
  begin
    rstz = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_6M);
    #1;
    rstz = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import bt_pkg::*;

  //////////////////////////////////////////////////
  // limits and constants
  //////////////////////////////////////////////////

  // up to 8 bit errors still count as a hit
  localparam logic [CORR_W-1:0] THRESHOLD = 7'd56;
  // native clock advances once per 1875 cycles
  localparam int CYC_PER_CLKN = 1875;
  // 64 bits of 6 cycles plus alignment and settle
  localparam int WORD_CYCLES  = 400;
  // 6 clkn samples of up to 4096 cycles plus 9 words and the pulses
  localparam int TEST_CYCLES    = 6 * 4096 + 9 * WORD_CYCLES + 200;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic              clk_6M;
  logic              rstz;
  sync_words_t       words;
  scan_cfg_t         scan_cfg;
  logic [CORR_W-1:0] corr_threshold;
  logic              page_scan_enable_p;
  logic              page_scan_cancel_p;
  logic              inquiry_scan_enable;
  logic              conn_hold_p;
  logic              rxbit;
  link_state_t       link_state;
  sync_events_t      events;
  logic [CLKN_W-1:0] clkn;

  tb_clkgen u_clkgen (
    .clk_6M (clk_6M),
    .rstz   (rstz)
  );

  bt_rx_sync_top DUT (
    .clk_6M              (clk_6M),
    .rstz                (rstz),
    .words               (words),
    .scan_cfg            (scan_cfg),
    .corr_threshold      (corr_threshold),
    .page_scan_enable_p  (page_scan_enable_p),
    .page_scan_cancel_p  (page_scan_cancel_p),
    .inquiry_scan_enable (inquiry_scan_enable),
    .conn_hold_p         (conn_hold_p),
    .rxbit               (rxbit),
    .link_state          (link_state),
    .events              (events),
    .clkn                (clkn)
  );

  //////////////////////////////////////////////////
  // cycle counters, watchdog, event monitor
  //////////////////////////////////////////////////

  // rising edges since reset release
  int    cyc;
  int    wd_cyc = 0;
  int    ps_cnt = 0;
  int    is_cnt = 0;
  int    conn_cnt = 0;
  int    ps_base;
  int    is_base;
  int    conn_base;
  string cur_test;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  logic [31:0] lfsr;

  always @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  always @(posedge clk_6M)
  begin
    wd_cyc <= wd_cyc + 1;
    if (wd_cyc >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not end within %0d cycles, stuck in %s",
               TIMEOUT_CYCLES, cur_test);
      $display("tests failed");
      $finish;
    end
  end

  // sync event pulses counted on the falling edge
  always @(negedge clk_6M)
  begin
    if (events.ps_sync_p)
      ps_cnt <= ps_cnt + 1;
    if (events.is_sync_p)
      is_cnt <= is_cnt + 1;
    if (events.conn_sync_p)
      conn_cnt <= conn_cnt + 1;
  end

  //////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [63:0] r);
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
  endtask

  // number of equal bit positions between sent and expected word
  function automatic int agreement(input logic [SYNC_W-1:0] a, input logic [SYNC_W-1:0] b);
    return $countones(~(a ^ b));
  endfunction

  // n random positions where repeats may cancel
  task automatic flip_random(inout logic [SYNC_W-1:0] w, input int n);
    logic [63:0] r;
    for (int k = 0; k < n; k++)
    begin
      draw_bits(6, r);
      w[r[5:0]] = ~w[r[5:0]];
    end
  endtask

  //////////////////////////////////////////////////
  // drive and check helpers
  //////////////////////////////////////////////////

  // land 1 ns after a rising edge
  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk_6M);
    #1;
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  // pulses seen since the last call
  task automatic check_events(input int exp_ps, input int exp_is, input int exp_conn);
    check("ps_sync_p count", 64'(exp_ps), 64'(ps_cnt - ps_base));
    check("is_sync_p count", 64'(exp_is), 64'(is_cnt - is_base));
    check("conn_sync_p count", 64'(exp_conn), 64'(conn_cnt - conn_base));
    ps_base   = ps_cnt;
    is_base   = is_cnt;
    conn_base = conn_cnt;
  endtask

  // msb first with each bit held over one full microsecond
  task automatic send_word(input logic [SYNC_W-1:0] w);
    // sampling edges fall on multiples of 6 after release
    while (cyc % 6 != 0)
      step_cycles(1);
    for (int i = SYNC_W - 1; i >= 0; i--)
    begin
      rxbit = w[i];
      step_cycles(6);
    end
    // idle line leaves room for the hit two edges later
    rxbit = 1'b0;
    step_cycles(6);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0)
      $display("test %s: pass", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s: %0d mismatches", cur_test, test_errs);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [63:0]       r;
    logic [SYNC_W-1:0] w;
    logic [5:0]        p;
    int                nerr;
    bit                hit;

    lfsr         = 32'h962d;
    cur_test     = "reset";
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    draw_bits(64, r);
    words.cac  = r;
    draw_bits(64, r);
    words.dac  = r;
    draw_bits(64, r);
    words.giac = r;
    // 4 slot interval with listening in the first 2
    scan_cfg.ps_interval = 16'd4;
    scan_cfg.ps_window   = 16'd2;
    scan_cfg.is_interval = 16'd4;
    scan_cfg.is_window   = 16'd2;
    corr_threshold       = THRESHOLD;
    page_scan_enable_p   = 1'b0;
    page_scan_cancel_p   = 1'b0;
    inquiry_scan_enable  = 1'b0;
    conn_hold_p          = 1'b0;
    rxbit                = 1'b0;

    @(posedge rstz);
    ps_base   = ps_cnt;
    is_base   = is_cnt;
    conn_base = conn_cnt;

    // clkn = edges / 1875
    begin_test("native_clock");
    check("link_state", 64'(ST_STANDBY), 64'(link_state));
    check("events", 64'(0), 64'(events));
    check("clkn", 64'(0), 64'(clkn));
    for (int s = 0; s < 6; s++)
    begin
      draw_bits(12, r);
      step_cycles(int'(r[11:0]) + 1);
      check("clkn", 64'(cyc / CYC_PER_CLKN), 64'(clkn));
    end
    // no pulse while idle in standby
    check_events(0, 0, 0);
    end_test();

    // three tries with random errors then a clean one
    begin_test("page_scan");
    page_scan_enable_p = 1'b1;
    step_cycles(1);
    page_scan_enable_p = 1'b0;
    check("link_state", 64'(ST_PAGE_SCAN), 64'(link_state));
    hit = 1'b0;
    for (int a = 0; a < 4 && !hit; a++)
    begin
      w    = words.dac;
      nerr = 0;
      if (a < 3)
      begin
        draw_bits(4, r);
        nerr = int'(r[3:0]);
      end
      flip_random(w, nerr);
      hit = (agreement(w, words.dac) >= int'(THRESHOLD));
      send_word(w);
      check_events(hit ? 1 : 0, 0, 0);
      check("link_state", 64'(hit ? ST_CONN : ST_PAGE_SCAN), 64'(link_state));
    end
    end_test();

    begin_test("connection");
    send_word(words.cac);
    check_events(0, 0, 1);
    conn_hold_p = 1'b1;
    step_cycles(1);
    conn_hold_p = 1'b0;
    check("link_state", 64'(ST_STANDBY), 64'(link_state));
    end_test();

    begin_test("inquiry_scan");
    inquiry_scan_enable = 1'b1;
    step_cycles(1);
    check("link_state", 64'(ST_INQ_SCAN), 64'(link_state));
    // 16 adjacent flips that may wrap past bit 63
    draw_bits(6, r);
    w = words.giac;
    for (int k = 0; k < 16; k++)
    begin
      p    = r[5:0] + 6'(k);
      w[p] = ~w[p];
    end
    send_word(w);
    check_events(0, (agreement(w, words.giac) >= int'(THRESHOLD)) ? 1 : 0, 0);
    send_word(words.giac);
    check_events(0, 1, 0);
    check("link_state", 64'(ST_INQ_SCAN), 64'(link_state));
    inquiry_scan_enable = 1'b0;
    step_cycles(1);
    check("link_state", 64'(ST_STANDBY), 64'(link_state));
    end_test();

    // correlator muted outside scan and link
    begin_test("standby_cancel");
    send_word(words.cac);
    check_events(0, 0, 0);
    page_scan_enable_p = 1'b1;
    step_cycles(1);
    page_scan_enable_p = 1'b0;
    check("link_state", 64'(ST_PAGE_SCAN), 64'(link_state));
    page_scan_cancel_p = 1'b1;
    step_cycles(1);
    page_scan_cancel_p = 1'b0;
    check("link_state", 64'(ST_STANDBY), 64'(link_state));
    send_word(words.dac);
    check_events(0, 0, 0);
    check("link_state", 64'(ST_STANDBY), 64'(link_state));
    end_test();

    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
bt_pkg.sv
bt_native_clk.sv
rx_sync_correlator.sv
scan_ctrl.sv
bt_rx_sync_top.sv
bt_rx_checker.sv
tb_clkgen.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f list.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
